// ==== Makefile ====
# Verilator build and run for the RP drive register block

VERILATOR ?= verilator
TOP       ?= rpControllerTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= All tests passed!

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	$(SIM_BIN) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation FAILED, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/rpController.sv ====
/*
 * RP drive register block top level
 * Write decoder, array of drives, read multiplexer
 */
`timescale 1ns/10ps
`default_nettype none

module rpController import rpPkg::*;
#(
   parameter int numDrives = 4,
   parameter int numCyl    = 815,
   parameter int numTrk    = 19,
   parameter int numSect   = 22,
   parameter int seekTime  = 40
)
(
   input  wire                  clk,
   input  wire                  rst,
   input  wire rpBusReq         busReq,
   input  wire [numDrives-1:0]  wrLock,
   output logic [15:0]          rdData,
   output logic                 rdValid,
   output logic [numDrives-1:0] atten
);

   rpDrvWr               drvWr;
   rpDrvStat             drvStat [numDrives];
   logic [numDrives-1:0] drvAttn;

   // Host writes, one cycle to the drives
   rpRegDecode decode (
      .clk    (clk),
      .rst    (rst),
      .busReq (busReq),
      .drvWr  (drvWr)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Drives, each matches its own index against the strobe
   ////////////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < numDrives; i++)
   begin : genDrive
      rpDrive #(
         .driveNum (i),
         .numCyl   (numCyl),
         .numTrk   (numTrk),
         .numSect  (numSect),
         .seekTime (seekTime)
      ) drive (
         .clk    (clk),
         .rst    (rst),
         .drvWr  (drvWr),
         .wrLock (wrLock[i]),
         .stat   (drvStat[i]),
         .attn   (drvAttn[i])
      );
   end

   // Read-back and attention summary
   rpReadMux #(
      .numDrives (numDrives)
   ) readMux (
      .clk     (clk),
      .rst     (rst),
      .busReq  (busReq),
      .stat    (drvStat),
      .attnIn  (drvAttn),
      .rdData  (rdData),
      .rdValid (rdValid),
      .atten   (atten)
   );

endmodule

`default_nettype wire

// ==== design/rpDrive.sv ====
/*
 * One RP drive
 * CS1, DA, DC and DS registers, function FSM, geometry check, attention, ER1
 */
`timescale 1ns/10ps
`default_nettype none

module rpDrive import rpPkg::*;
#(
   parameter int driveNum = 0,
   parameter int numCyl   = 815,
   parameter int numTrk   = 19,
   parameter int numSect  = 22,
   parameter int seekTime = 40
)
(
   input  wire         clk,
   input  wire         rst,
   input  wire rpDrvWr drvWr,
   input  wire         wrLock,
   output rpDrvStat    stat,
   output logic        attn
);

   localparam int cntW = $clog2(seekTime + 1);

   typedef enum logic {stIdle, stSeek} rpState;

   rpState          state;
   logic [cntW-1:0] count;
   logic [4:0]      cs1Func;
   logic [15:0]     da;
   logic [15:0]     dc;
   logic [15:0]     er1;
   logic [15:0]     ds;
   logic            ata;

   // Write decode
   logic  hit;
   logic  busy;
   logic  regWrOk;
   logic  badAddr;
   rpFunc func;

   // Actions for this cycle
   logic  setIlf;
   logic  setRmr;
   logic  setIae;
   logic  setWle;
   logic  setPar;
   logic  setAta;
   logic  clrAta;
   logic  drvClr;
   logic  er1Write;
   logic  startSeek;
   logic  seekDone;

   assign hit      = drvWr.valid && (drvWr.drive == 3'(driveNum));
   assign busy     = (state == stSeek);
   assign regWrOk  = hit && !drvWr.parErr && !busy;
   assign func     = rpFunc'(drvWr.data[5:1]);
   assign seekDone = busy && (count == '0);

   // Address checked against pack geometry at GO time
   assign badAddr = (dc >= 16'(numCyl)) ||
                    (da[daTrkHi:daTrkLo] >= 5'(numTrk)) ||
                    (da[daSecHi:daSecLo] >= 5'(numSect));

   ////////////////////////////////////////////////////////////////////////////
   // Write rules in priority order
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      setIlf    = 1'b0;
      setRmr    = 1'b0;
      setIae    = 1'b0;
      setWle    = 1'b0;
      setPar    = 1'b0;
      setAta    = 1'b0;
      clrAta    = 1'b0;
      drvClr    = 1'b0;
      er1Write  = 1'b0;
      startSeek = 1'b0;
      if (hit)
      begin
         if (drvWr.parErr)
         begin
            setPar = 1'b1;
            setAta = 1'b1;
         end
         else if (busy && (drvWr.regSel inside {regCs1, regDa, regDc}))
         begin
            setRmr = 1'b1;
         end
         else if (drvWr.regSel == regEr1)
         begin
            er1Write = 1'b1;
         end
         else if ((drvWr.regSel == regCs1) && drvWr.data[cs1Go])
         begin
            // Any GO drops attention before the function runs
            clrAta = 1'b1;
            case (func)
               fnNop, fnRead:
               begin
               end
               fnDrvClr:
               begin
                  drvClr = 1'b1;
               end
               fnWrite:
               begin
                  setWle = wrLock;
                  setAta = wrLock;
               end
               fnSeek, fnSearch:
               begin
                  setIae    = badAddr;
                  setAta    = badAddr;
                  startSeek = !badAddr;
               end
               fnRecal:
               begin
                  startSeek = 1'b1;
               end
               default:
               begin
                  setIlf = 1'b1;
                  setAta = 1'b1;
               end
            endcase
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Registers and seek timer
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         cs1Func <= '0;
         da      <= '0;
         dc      <= '0;
      end
      else if (regWrOk)
      begin
         case (drvWr.regSel)
            regCs1:  cs1Func <= drvWr.data[5:1];
            regDa:   da      <= drvWr.data;
            regDc:   dc      <= drvWr.data;
            default: ;
         endcase
      end
   end

   // Positioner busy for seekTime cycles
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state <= stIdle;
         count <= '0;
      end
      else if (startSeek)
      begin
         state <= stSeek;
         count <= cntW'(seekTime - 1);
      end
      else if (seekDone)
      begin
         state <= stIdle;
      end
      else if (busy)
      begin
         count <= count - 1'b1;
      end
   end

   // Attention, a set in the same cycle beats the GO clear
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         ata <= 1'b0;
      else if (setAta || seekDone)
         ata <= 1'b1;
      else if (clrAta)
         ata <= 1'b0;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Error latches and status
   ////////////////////////////////////////////////////////////////////////////

   // No controller wide clear exists in this block
   rpEr1 er1Regs (
      .clk      (clk),
      .rst      (rst),
      .clr      (1'b0),
      .drvClr   (drvClr),
      .setIlf   (setIlf),
      .setRmr   (setRmr),
      .setIae   (setIae),
      .setWle   (setWle),
      .setPar   (setPar),
      .wrData   (drvWr.data),
      .er1Write (er1Write),
      .drvReady (!busy),
      .er1      (er1)
   );

   // DS built from live state
   always_comb
   begin
      ds        = '0;
      ds[dsAta] = ata;
      ds[dsErr] = |er1;
      ds[dsWrl] = wrLock;
      ds[dsDry] = !busy;
   end

   // GO reads back set while the drive is positioning
   assign stat = '{
      cs1: {10'b0, cs1Func, busy},
      ds:  ds,
      er1: er1,
      da:  da,
      dc:  dc
   };

   assign attn = ata;

endmodule

`default_nettype wire

// ==== design/rpEr1.sv ====
/*
 * ER1 error latches for one drive
 * Clear first, then hardware set pulses, then host write while ready
 */
`timescale 1ns/10ps
`default_nettype none

module rpEr1 import rpPkg::*;
(
   input  wire        clk,
   input  wire        rst,
   input  wire        clr,
   input  wire        drvClr,
   input  wire        setIlf,
   input  wire        setRmr,
   input  wire        setIae,
   input  wire        setWle,
   input  wire        setPar,
   input  wire [15:0] wrData,
   input  wire        er1Write,
   input  wire        drvReady,
   output logic [15:0] er1
);

   ////////////////////////////////////////////////////////////////////////////
   // Set and write controls
   ////////////////////////////////////////////////////////////////////////////

   logic [15:0] setVec;
   logic        clearAll;
   logic        hostWr;

   // Gather the set pulses into bit positions
   always_comb
   begin
      setVec         = '0;
      setVec[er1Ilf] = setIlf;
      setVec[er1Rmr] = setRmr;
      setVec[er1Iae] = setIae;
      setVec[er1Wle] = setWle;
      setVec[er1Par] = setPar;
   end

   assign clearAll = clr | drvClr;

   // Host write ignored while the drive is busy
   assign hostWr = er1Write & drvReady;

   ////////////////////////////////////////////////////////////////////////////
   // Latches
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         er1 <= '0;
      end
      else if (clearAll)
      begin
         er1 <= '0;
      end
      else
      begin
         for (int b = 0; b < 16; b++)
         begin
            // Set pulse wins over a host write in the same cycle
            if (setVec[b])
               er1[b] <= 1'b1;
            else if (hostWr)
               er1[b] <= wrData[b];
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/rpPkg.sv ====
/*
 * Shared types for the RP drive register block
 * Function and register enums, host and drive structs, register bit positions
 */
`default_nettype none

package rpPkg;

   ////////////////////////////////////////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////////////////////////////////////////

   // Function code from CS1 bits 5:1
   typedef enum logic [4:0] {
      fnNop    = 5'd0,
      fnSeek   = 5'd2,
      fnRecal  = 5'd3,
      fnDrvClr = 5'd4,
      fnSearch = 5'd12,
      fnWrite  = 5'd24,
      fnRead   = 5'd28
   } rpFunc;

   // Register select, codes 5 to 7 unused
   typedef enum logic [2:0] {
      regCs1 = 3'd0,
      regDs  = 3'd1,
      regEr1 = 3'd2,
      regDa  = 3'd3,
      regDc  = 3'd4
   } rpReg;

   ////////////////////////////////////////////////////////////////////////////
   // Bus and status bundles
   ////////////////////////////////////////////////////////////////////////////

   // One host request, par is odd parity over data 15:0
   typedef struct packed {
      logic        write;
      logic        read;
      logic [2:0]  drive;
      rpReg        regSel;
      logic [35:0] data;
      logic        par;
   } rpBusReq;

   // Registered write strobe broadcast to every drive
   typedef struct packed {
      logic        valid;
      logic [2:0]  drive;
      rpReg        regSel;
      logic [15:0] data;
      logic        parErr;
   } rpDrvWr;

   // Readable state of one drive
   typedef struct packed {
      logic [15:0] cs1;
      logic [15:0] ds;
      logic [15:0] er1;
      logic [15:0] da;
      logic [15:0] dc;
   } rpDrvStat;

   ////////////////////////////////////////////////////////////////////////////
   // Bit positions
   ////////////////////////////////////////////////////////////////////////////

   // ER1
   localparam int er1Dck  = 15;
   localparam int er1Uns  = 14;
   localparam int er1Opi  = 13;
   localparam int er1Dte  = 12;
   localparam int er1Wle  = 11;
   localparam int er1Iae  = 10;
   localparam int er1Aoe  = 9;
   localparam int er1Hcrc = 8;
   localparam int er1Hce  = 7;
   localparam int er1Ech  = 6;
   localparam int er1Wcf  = 5;
   localparam int er1Fer  = 4;
   localparam int er1Par  = 3;
   localparam int er1Rmr  = 2;
   localparam int er1Ilr  = 1;
   localparam int er1Ilf  = 0;

   // DS
   localparam int dsAta = 15;
   localparam int dsErr = 14;
   localparam int dsWrl = 11;
   localparam int dsDry = 7;

   // CS1 GO bit
   localparam int cs1Go = 0;

   // DA fields
   localparam int daTrkHi = 12;
   localparam int daTrkLo = 8;
   localparam int daSecHi = 4;
   localparam int daSecLo = 0;

endpackage

`default_nettype wire

// ==== design/rpReadMux.sv ====
/*
 * Read-back path
 * Registered read of the selected drive register and attention summary
 */
`timescale 1ns/10ps
`default_nettype none

module rpReadMux import rpPkg::*;
#(
   parameter int numDrives = 4
)
(
   input  wire           clk,
   input  wire           rst,
   input  wire rpBusReq  busReq,
   input  wire rpDrvStat stat [numDrives],
   input  wire [numDrives-1:0] attnIn,
   output logic [15:0]   rdData,
   output logic          rdValid,
   output logic [numDrives-1:0] atten
);

   rpDrvStat    selStat;
   logic [15:0] selData;

   // Drive select, missing drives read as zero
   always_comb
   begin
      selStat = '0;
      for (int i = 0; i < numDrives; i++)
      begin
         if (busReq.drive == 3'(i))
            selStat = stat[i];
      end
   end

   // Register select, unused codes read as zero
   always_comb
   begin
      case (busReq.regSel)
         regCs1:  selData = selStat.cs1;
         regDs:   selData = selStat.ds;
         regEr1:  selData = selStat.er1;
         regDa:   selData = selStat.da;
         regDc:   selData = selStat.dc;
         default: selData = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Output registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rdValid <= 1'b0;
         atten   <= '0;
      end
      else
      begin
         rdValid <= busReq.read;
         atten   <= attnIn;
      end
   end

   // Data held until the next read
   always_ff @(posedge clk)
   begin
      if (busReq.read)
         rdData <= selData;
   end

endmodule

`default_nettype wire

// ==== design/rpRegDecode.sv ====
/*
 * Host write decoder
 * Registers host writes into the drive strobe and checks bus parity
 */
`timescale 1ns/10ps
`default_nettype none

module rpRegDecode import rpPkg::*;
(
   input  wire          clk,
   input  wire          rst,
   input  wire rpBusReq busReq,
   output rpDrvWr       drvWr
);

   // Strobe and captured payload
   logic        wrValid;
   logic [2:0]  wrDrive;
   rpReg        wrReg;
   logic [15:0] wrData;
   logic        wrParErr;

   // Parity good when data and par together hold an odd count of ones
   logic        parOk;

   assign parOk = ^{busReq.data[15:0], busReq.par};

   ////////////////////////////////////////////////////////////////////////////
   // Write strobe
   ////////////////////////////////////////////////////////////////////////////

   // One cycle pulse per host write, reads are dropped here
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wrValid <= 1'b0;
      end
      else
      begin
         wrValid <= busReq.write;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Payload capture
   ////////////////////////////////////////////////////////////////////////////

   // Drive and register select, low data word, parity flag
   always_ff @(posedge clk)
   begin
      if (busReq.write)
      begin
         wrDrive  <= busReq.drive;
         wrReg    <= busReq.regSel;
         wrData   <= busReq.data[15:0];
         wrParErr <= ~parOk;
      end
   end

   // Broadcast bundle
   assign drvWr = '{
      valid:  wrValid,
      drive:  wrDrive,
      regSel: wrReg,
      data:   wrData,
      parErr: wrParErr
   };

endmodule

`default_nettype wire

// ==== files.f ====
design/rpPkg.sv
design/rpRegDecode.sv
design/rpEr1.sv
design/rpDrive.sv
design/rpReadMux.sv
design/rpController.sv
testbench/rpControllerProperties.sv
testbench/rpControllerTb.sv

// ==== testbench/rpControllerProperties.sv ====
/*
 * Concurrent checks on the RP controller, bound to the top level
 * Read pulse width, ER1 under reset, bounded positioner busy time
 */
`timescale 1ns/10ps
`default_nettype none

module rpControllerProperties import rpPkg::*;
#(
   parameter int numDrives = 4,
   parameter int seekTime  = 40
)
(
   input  wire           clk,
   input  wire           rst,
   input  wire           rdValid,
   input  wire rpDrvStat drvStat [numDrives]
);

   // Sticky flags, read by the testbench summary
   logic                 rdValidFail = 1'b0;
   logic [numDrives-1:0] drvFail;
   logic                 failSeen;

   // One read, one valid pulse
   rdValidPulse: assert property (@(posedge clk) disable iff (rst) rdValid |=> !rdValid)
   else
   begin
      $error("rdValid held high for two cycles");
      rdValidFail = 1'b1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Per drive checks
   ////////////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < numDrives; i++)
   begin : genDrvChk
      logic [15:0] lowCount;
      logic        er1Fail = 1'b0;
      logic        dryFail = 1'b0;

      // Cycles spent with DRY low
      always_ff @(posedge clk or posedge rst)
      begin
         if (rst)
            lowCount <= '0;
         else if (drvStat[i].ds[dsDry])
            lowCount <= '0;
         else
            lowCount <= lowCount + 16'd1;
      end

      er1InReset: assert property (@(posedge clk) rst |-> (drvStat[i].er1 == '0))
      else
      begin
         $error("ER1 of drive %0d nonzero during reset", i);
         er1Fail = 1'b1;
      end

      // Seek lasts seekTime, two cycles of slack
      dryLowBound: assert property (@(posedge clk) disable iff (rst)
                                    lowCount <= 16'(seekTime + 2))
      else
      begin
         $error("DRY of drive %0d low too long", i);
         dryFail = 1'b1;
      end

      assign drvFail[i] = er1Fail | dryFail;
   end

   assign failSeen = rdValidFail | (|drvFail);

endmodule

`default_nettype wire

// ==== testbench/rpControllerTb.sv ====
/*
 * Testbench for the RP drive register block
 * Clock, reset, host bus tasks, LFSR data, directed tests, watchdog, summary
 */
`timescale 1ns/10ps
`default_nettype none

module rpControllerTb import rpPkg::*;
();

   localparam int numDrives   = 4;
   localparam int numCyl      = 815;
   localparam int numTrk      = 19;
   localparam int numSect     = 22;
   localparam int seekTime    = 40;
   localparam int resetCycles = 8;

   // Run limit from test count and seek length
   localparam int numTests       = 6;
   localparam int cyclesPerTest  = 8 * seekTime + 12;
   localparam int watchdogCycles = resetCycles + numTests * cyclesPerTest;

   // Not a legal function code
   localparam logic [4:0] illegalCode = 5'd1;

   logic                 clk = 1'b0;
   logic                 rst;
   rpBusReq              busReq;
   logic [numDrives-1:0] wrLock;
   logic [15:0]          rdData;
   logic                 rdValid;
   logic [numDrives-1:0] atten;

   int          checkCount;
   int          errCount;
   string       testName;
   logic [31:0] lfsrState;

   rpController #(
      .numDrives (numDrives),
      .numCyl    (numCyl),
      .numTrk    (numTrk),
      .numSect   (numSect),
      .seekTime  (seekTime)
   ) UUT (
      .clk     (clk),
      .rst     (rst),
      .busReq  (busReq),
      .wrLock  (wrLock),
      .rdData  (rdData),
      .rdValid (rdValid),
      .atten   (atten)
   );

   bind rpController rpControllerProperties #(
      .numDrives (numDrives),
      .seekTime  (seekTime)
   ) props (
      .clk     (clk),
      .rst     (rst),
      .rdValid (rdValid),
      .drvStat (drvStat)
   );

   // 100 ns period
   always #50 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Data helpers
   ////////////////////////////////////////////////////////////////////////////

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      else
         return s >> 1;
   endfunction

   // One LFSR step per bit
   function automatic logic [15:0] randomWord();
      logic [15:0] w;
      w = '0;
      for (int b = 0; b < 16; b++)
      begin
         lfsrState = lfsrStep(lfsrState);
         w = {w[14:0], lfsrState[0]};
      end
      return w;
   endfunction

   // Makes the total count of ones odd
   function automatic logic oddParity(input logic [15:0] d);
      return ~(^d);
   endfunction

   function automatic logic [15:0] bitWord(input int pos);
      return 16'h0001 << pos;
   endfunction

   // CS1 with GO
   function automatic logic [15:0] goWord(input logic [4:0] code);
      return {10'b0, code, 1'b1};
   endfunction

   function automatic logic [15:0] daWord(input int trk, input int sect);
      return {3'b0, 5'(trk), 3'b0, 5'(sect)};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Bus tasks and checks
   ////////////////////////////////////////////////////////////////////////////

   // flipPar forces a parity error
   task automatic driveWrite(input int drv, input rpReg r, input logic [15:0] d,
                             input logic flipPar);
      @(posedge clk);
      #5;
      busReq.write  = 1'b1;
      busReq.drive  = 3'(drv);
      busReq.regSel = r;
      busReq.data   = {20'b0, d};
      busReq.par    = oddParity(d) ^ flipPar;
      @(posedge clk);
      #5;
      busReq.write = 1'b0;
      // Decoder plus drive register
      repeat (2) @(posedge clk);
      #5;
   endtask

   task automatic busWrite(input int drv, input rpReg r, input logic [15:0] d);
      driveWrite(drv, r, d, 1'b0);
   endtask

   task automatic busRead(input int drv, input rpReg r, output logic [15:0] d);
      int waitCycles;
      @(posedge clk);
      #5;
      busReq.read   = 1'b1;
      busReq.drive  = 3'(drv);
      busReq.regSel = r;
      @(posedge clk);
      #5;
      busReq.read = 1'b0;
      waitCycles  = 0;
      while (!rdValid && waitCycles < 4)
      begin
         @(posedge clk);
         #5;
         waitCycles++;
      end
      assert (rdValid)
      else
      begin
         errCount++;
         $display("No read response from drive %0d in test %s", drv, testName);
      end
      d = rdData;
   endtask

   task automatic checkValue(input string what, input logic [15:0] expected,
                             input logic [15:0] actual);
      checkCount++;
      assert (actual === expected)
      else
      begin
         errCount++;
         $display("ERROR %s %s: expected %h, actual %h", testName, what, expected, actual);
      end
   endtask

   task automatic checkReg(input int drv, input rpReg r, input logic [15:0] expected);
      logic [15:0] value;
      busRead(drv, r, value);
      checkValue($sformatf("drive %0d %s", drv, r.name()), expected, value);
   endtask

   task automatic checkAtten(input logic [numDrives-1:0] expected);
      checkValue("atten", 16'(expected), 16'(atten));
   endtask

   // Poll DS until DRY returns
   task automatic waitReady(input int drv);
      logic [15:0] ds;
      int          polls;
      ds    = '0;
      polls = 0;
      while (!ds[dsDry] && polls < 4 * seekTime)
      begin
         busRead(drv, regDs, ds);
         polls++;
      end
      assert (ds[dsDry])
      else
      begin
         errCount++;
         $display("Drive %0d never became ready in test %s", drv, testName);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic testReset();
      testName = "reset";
      for (int d = 0; d < numDrives; d++)
      begin
         checkReg(d, regEr1, 16'h0000);
         checkReg(d, regCs1, 16'h0000);
         checkReg(d, regDa, 16'h0000);
         checkReg(d, regDc, 16'h0000);
         checkReg(d, regDs, bitWord(dsDry));
      end
      checkAtten('0);
   endtask

   task automatic testEr1Write();
      logic [15:0] er1Val [numDrives];
      testName = "er1Write";
      for (int d = 0; d < numDrives; d++)
      begin
         er1Val[d] = randomWord();
         busWrite(d, regEr1, er1Val[d]);
      end
      for (int d = 0; d < numDrives; d++)
         checkReg(d, regEr1, er1Val[d]);
      // Clear drive 1 only
      busWrite(1, regCs1, goWord(fnDrvClr));
      for (int d = 0; d < numDrives; d++)
         checkReg(d, regEr1, (d == 1) ? 16'h0000 : er1Val[d]);
      checkReg(1, regDs, bitWord(dsDry));
      for (int d = 0; d < numDrives; d++)
         busWrite(d, regCs1, goWord(fnDrvClr));
   endtask

   task automatic testIllegalFunc();
      testName = "illegalFunc";
      busWrite(3, regCs1, goWord(illegalCode));
      checkReg(3, regEr1, bitWord(er1Ilf));
      checkReg(3, regDs, bitWord(dsAta) | bitWord(dsErr) | bitWord(dsDry));
      checkAtten(4'b1000);
      // Bad parity is dropped, PAR joins ILF
      busWrite(3, regDc, 16'h0055);
      driveWrite(3, regDc, 16'h0123, 1'b1);
      checkReg(3, regDc, 16'h0055);
      checkReg(3, regEr1, bitWord(er1Ilf) | bitWord(er1Par));
      busWrite(3, regCs1, goWord(fnDrvClr));
      checkAtten('0);
   endtask

   task automatic testSeek();
      logic [15:0] ds;
      testName = "seek";
      busWrite(0, regDc, 16'd100);
      busWrite(0, regDa, daWord(5, 7));
      busWrite(0, regCs1, goWord(fnSeek));
      busRead(0, regDs, ds);
      checkValue("DRY while seeking", 16'h0000, {15'b0, ds[dsDry]});
      // Busy drive refuses the new cylinder
      busWrite(0, regDc, 16'd200);
      checkReg(0, regEr1, bitWord(er1Rmr));
      waitReady(0);
      checkReg(0, regDc, 16'd100);
      checkReg(0, regDs, bitWord(dsAta) | bitWord(dsErr) | bitWord(dsDry));
      checkAtten(4'b0001);
      busWrite(0, regCs1, goWord(fnDrvClr));
   endtask

   task automatic testGeometry();
      logic [15:0] errDs;
      errDs    = bitWord(dsAta) | bitWord(dsErr) | bitWord(dsDry);
      testName = "geometry";
      // Cylinder one past the end
      busWrite(1, regDc, 16'(numCyl));
      busWrite(1, regDa, daWord(0, 0));
      busWrite(1, regCs1, goWord(fnSeek));
      checkReg(1, regDs, errDs);
      checkReg(1, regEr1, bitWord(er1Iae));
      busWrite(1, regCs1, goWord(fnDrvClr));
      // Sector one past the end
      busWrite(1, regDc, 16'd0);
      busWrite(1, regDa, daWord(0, numSect));
      busWrite(1, regCs1, goWord(fnSeek));
      checkReg(1, regDs, errDs);
      checkReg(1, regEr1, bitWord(er1Iae));
      busWrite(1, regCs1, goWord(fnDrvClr));
      // Write to a locked and an unlocked drive
      @(posedge clk);
      #5;
      wrLock = 4'b0100;
      busWrite(2, regCs1, goWord(fnWrite));
      checkReg(2, regEr1, bitWord(er1Wle));
      checkReg(2, regDs, errDs | bitWord(dsWrl));
      busWrite(3, regCs1, goWord(fnWrite));
      checkReg(3, regEr1, 16'h0000);
      checkReg(3, regDs, bitWord(dsDry));
      busWrite(2, regCs1, goWord(fnDrvClr));
      @(posedge clk);
      #5;
      wrLock = '0;
      checkAtten('0);
   endtask

   task automatic testDualSeek();
      testName = "dualSeek";
      busWrite(0, regDc, 16'd300);
      busWrite(0, regDa, daWord(2, 3));
      busWrite(2, regDc, 16'd400);
      busWrite(2, regDa, daWord(18, 21));
      // Second seek starts while the first is running
      busWrite(0, regCs1, goWord(fnSeek));
      busWrite(2, regCs1, goWord(fnSeek));
      waitReady(0);
      waitReady(2);
      checkAtten(4'b0101);
      checkReg(0, regDc, 16'd300);
      checkReg(2, regDc, 16'd400);
      checkReg(0, regDs, bitWord(dsAta) | bitWord(dsDry));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Sequencing
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      rst        = 1'b1;
      busReq     = '0;
      wrLock     = '0;
      lfsrState  = 32'h25d2;
      checkCount = 0;
      errCount   = 0;
      testName   = "";
      repeat (resetCycles) @(posedge clk);
      #5;
      rst = 1'b0;
      testReset();
      testEr1Write();
      testIllegalFunc();
      testSeek();
      testGeometry();
      testDualSeek();
      $display("Checks: %0d, errors: %0d, assertion failure flagged: %0d",
               checkCount, errCount, UUT.props.failSeen);
      if (errCount == 0 && !UUT.props.failSeen)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

   // Hang guard
   initial
   begin
      repeat (watchdogCycles) @(posedge clk);
      $display("Timeout, tests still running after %0d cycles in %s", watchdogCycles,
               testName);
      $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire
